// ==== design/rv_pkg.sv ====
package rv_pkg;

    localparam int xlen = 64;

    // register value, address and instruction word
    typedef logic [xlen-1:0] reg_t;
    typedef logic [4:0]      reg_addr_t;
    typedef logic [31:0]     instr_t;

    typedef logic [3:0]      alu_op_t;

    // alu operation codes
    localparam alu_op_t alu_add  = 4'd0;
    localparam alu_op_t alu_sub  = 4'd1;
    localparam alu_op_t alu_sll  = 4'd2;
    localparam alu_op_t alu_slt  = 4'd3;
    localparam alu_op_t alu_sltu = 4'd4;
    localparam alu_op_t alu_xor  = 4'd5;
    localparam alu_op_t alu_srl  = 4'd6;
    localparam alu_op_t alu_sra  = 4'd7;
    localparam alu_op_t alu_or   = 4'd8;
    localparam alu_op_t alu_and  = 4'd9;
    localparam alu_op_t alu_lui  = 4'd10;

    // major opcodes, instr[6:0]
    localparam logic [6:0] opc_lui    = 7'b0110111;
    localparam logic [6:0] opc_op_imm = 7'b0010011;
    localparam logic [6:0] opc_op     = 7'b0110011;

    localparam reg_t zero_reg = '0;

endpackage

// ==== design/regfile.sv ====
`timescale 1ns/1ps

module regfile (
    input  logic              clk,
    input  logic              rst,
    // write channel
    input  rv_pkg::reg_addr_t w_addr,
    input  rv_pkg::reg_t      w_data,
    input  logic              w_ena,
    // read channel 1
    input  rv_pkg::reg_addr_t r_addr1,
    input  logic              r_ena1,
    output rv_pkg::reg_t      r_data1,
    // read channel 2
    input  rv_pkg::reg_addr_t r_addr2,
    input  logic              r_ena2,
    output rv_pkg::reg_t      r_data2
);

    rv_pkg::reg_t regs [0:31];

    // zero when disabled or in reset
    function automatic rv_pkg::reg_t read_port(
        input rv_pkg::reg_addr_t addr,
        input logic              ena,
        input logic              in_reset
    );
        rv_pkg::reg_t value;
        value = rv_pkg::zero_reg;
        if (!in_reset && ena) begin
            value = regs[addr];
        end
        return value;
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= rv_pkg::zero_reg;
            end
        end else if (w_ena && (w_addr != 5'd0)) begin
            // r0 never written
            regs[w_addr] <= w_data;
        end
    end

    always_comb begin
        r_data1 = read_port(r_addr1, r_ena1, rst);
    end

    always_comb begin
        r_data2 = read_port(r_addr2, r_ena2, rst);
    end

    // r0 stays zero whatever the write history
    r0_reads_zero_1: assert property (
        @(posedge clk) (r_ena1 && (r_addr1 == 5'd0)) |-> (r_data1 == rv_pkg::zero_reg)
    );

    r0_reads_zero_2: assert property (
        @(posedge clk) (r_ena2 && (r_addr2 == 5'd0)) |-> (r_data2 == rv_pkg::zero_reg)
    );

endmodule

// ==== design/instr_decode.sv ====
`timescale 1ns/1ps

module instr_decode (
    input  rv_pkg::instr_t    instr,
    output rv_pkg::reg_addr_t rs1_addr,
    output rv_pkg::reg_addr_t rs2_addr,
    output rv_pkg::reg_addr_t rd_addr,
    output logic              rs1_ena,
    output logic              rs2_ena,
    output rv_pkg::reg_t      imm,
    output logic              use_imm,
    output rv_pkg::alu_op_t   alu_op,
    output logic              legal
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    assign rd_addr  = instr[11:7];
    assign rs1_addr = instr[19:15];
    assign rs2_addr = instr[24:20];

    always_comb begin
        legal   = 1'b0;
        use_imm = 1'b0;
        alu_op  = rv_pkg::alu_add;
        imm     = rv_pkg::zero_reg;

        case (opcode)
            rv_pkg::opc_lui: begin
                legal   = 1'b1;
                use_imm = 1'b1;
                alu_op  = rv_pkg::alu_lui;
                imm     = {{32{instr[31]}}, instr[31:12], 12'b0};
            end

            rv_pkg::opc_op_imm: begin
                legal   = 1'b1;
                use_imm = 1'b1;
                imm     = {{52{instr[31]}}, instr[31:20]};
                case (funct3)
                    3'b000: alu_op = rv_pkg::alu_add;
                    3'b010: alu_op = rv_pkg::alu_slt;
                    3'b011: alu_op = rv_pkg::alu_sltu;
                    3'b100: alu_op = rv_pkg::alu_xor;
                    3'b110: alu_op = rv_pkg::alu_or;
                    3'b111: alu_op = rv_pkg::alu_and;
                    3'b001: begin
                        // slli, 6-bit shamt
                        alu_op = rv_pkg::alu_sll;
                        imm    = {58'b0, instr[25:20]};
                        legal  = (instr[31:26] == 6'b000000);
                    end
                    default: begin
                        // srli / srai
                        alu_op = instr[30] ? rv_pkg::alu_sra : rv_pkg::alu_srl;
                        imm    = {58'b0, instr[25:20]};
                        legal  = !instr[31] && (instr[29:26] == 4'b0000);
                    end
                endcase
            end

            rv_pkg::opc_op: begin
                // only funct7 0x00, or 0x20 for sub / sra
                legal = (funct7 == 7'b0000000)
                     || ((funct7 == 7'b0100000) && ((funct3 == 3'b000) || (funct3 == 3'b101)));
                case (funct3)
                    3'b000:  alu_op = funct7[5] ? rv_pkg::alu_sub : rv_pkg::alu_add;
                    3'b001:  alu_op = rv_pkg::alu_sll;
                    3'b010:  alu_op = rv_pkg::alu_slt;
                    3'b011:  alu_op = rv_pkg::alu_sltu;
                    3'b100:  alu_op = rv_pkg::alu_xor;
                    3'b101:  alu_op = funct7[5] ? rv_pkg::alu_sra : rv_pkg::alu_srl;
                    3'b110:  alu_op = rv_pkg::alu_or;
                    default: alu_op = rv_pkg::alu_and;
                endcase
            end

            default: begin
                legal = 1'b0;
            end
        endcase
    end

    // read enables follow legality
    assign rs1_ena = legal && (opcode != rv_pkg::opc_lui);
    assign rs2_ena = legal && (opcode == rv_pkg::opc_op);

endmodule

// ==== design/alu.sv ====
`timescale 1ns/1ps

module alu (
    input  logic              clk,
    input  logic              rst,
    input  logic              instr_valid,
    input  logic              legal,
    input  rv_pkg::alu_op_t   alu_op,
    input  logic              use_imm,
    input  rv_pkg::reg_t      imm,
    input  rv_pkg::reg_t      rs1_data,
    input  rv_pkg::reg_t      rs2_data,
    input  rv_pkg::reg_addr_t rd_addr,
    // write channel to the register file
    output logic              w_ena,
    output rv_pkg::reg_addr_t w_addr,
    output rv_pkg::reg_t      w_data,
    // retire record
    output logic              retire_valid,
    output rv_pkg::reg_addr_t retire_rd,
    output rv_pkg::reg_t      retire_data,
    output logic              illegal
);

    rv_pkg::reg_t op_b;
    rv_pkg::reg_t result;
    logic [5:0]   shamt;

    assign op_b  = use_imm ? imm : rs2_data;
    assign shamt = op_b[5:0];

    always_comb begin
        case (alu_op)
            rv_pkg::alu_add:  result = rs1_data + op_b;
            rv_pkg::alu_sub:  result = rs1_data - op_b;
            rv_pkg::alu_sll:  result = rs1_data << shamt;
            rv_pkg::alu_slt:  result = rv_pkg::reg_t'($signed(rs1_data) < $signed(op_b));
            rv_pkg::alu_sltu: result = rv_pkg::reg_t'(rs1_data < op_b);
            rv_pkg::alu_xor:  result = rs1_data ^ op_b;
            rv_pkg::alu_srl:  result = rs1_data >> shamt;
            rv_pkg::alu_sra:  result = rv_pkg::reg_t'($signed(rs1_data) >>> shamt);
            rv_pkg::alu_or:   result = rs1_data | op_b;
            rv_pkg::alu_and:  result = rs1_data & op_b;
            // upper immediate already shifted by the decoder
            rv_pkg::alu_lui:  result = imm;
            default:          result = rv_pkg::zero_reg;
        endcase
    end

    // write lands at the same edge as the retire record
    assign w_ena  = instr_valid && legal;
    assign w_addr = rd_addr;
    assign w_data = result;

    always_ff @(posedge clk) begin
        if (rst) begin
            retire_valid <= 1'b0;
            illegal      <= 1'b0;
        end else begin
            retire_valid <= instr_valid && legal;
            illegal      <= instr_valid && !legal;
        end
    end

    // payload, kept even for rd == r0
    always_ff @(posedge clk) begin
        if (instr_valid) begin
            retire_rd   <= rd_addr;
            retire_data <= result;
        end
    end

    retire_xor_illegal: assert property (
        @(posedge clk) disable iff (rst) !(retire_valid && illegal)
    );

endmodule

// ==== design/rv_exec_top.sv ====
`timescale 1ns/1ps

module rv_exec_top (
    input  logic              clk,
    input  logic              rst,
    input  logic              instr_valid,
    input  rv_pkg::instr_t    instr,
    output logic              retire_valid,
    output rv_pkg::reg_addr_t retire_rd,
    output rv_pkg::reg_t      retire_data,
    output logic              illegal
);

    // decoder outputs
    rv_pkg::reg_addr_t rs1_addr;
    rv_pkg::reg_addr_t rs2_addr;
    rv_pkg::reg_addr_t rd_addr;
    logic              rs1_ena;
    logic              rs2_ena;
    rv_pkg::reg_t      imm;
    logic              use_imm;
    rv_pkg::alu_op_t   alu_op;
    logic              legal;

    // operands and write-back
    rv_pkg::reg_t      rs1_data;
    rv_pkg::reg_t      rs2_data;
    logic              w_ena;
    rv_pkg::reg_addr_t w_addr;
    rv_pkg::reg_t      w_data;

    instr_decode u_decode (
        .instr    (instr),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rd_addr  (rd_addr),
        .rs1_ena  (rs1_ena),
        .rs2_ena  (rs2_ena),
        .imm      (imm),
        .use_imm  (use_imm),
        .alu_op   (alu_op),
        .legal    (legal)
    );

    regfile u_regfile (
        .clk     (clk),
        .rst     (rst),
        .w_addr  (w_addr),
        .w_data  (w_data),
        .w_ena   (w_ena),
        .r_addr1 (rs1_addr),
        .r_ena1  (rs1_ena),
        .r_data1 (rs1_data),
        .r_addr2 (rs2_addr),
        .r_ena2  (rs2_ena),
        .r_data2 (rs2_data)
    );

    alu u_alu (
        .clk          (clk),
        .rst          (rst),
        .instr_valid  (instr_valid),
        .legal        (legal),
        .alu_op       (alu_op),
        .use_imm      (use_imm),
        .imm          (imm),
        .rs1_data     (rs1_data),
        .rs2_data     (rs2_data),
        .rd_addr      (rd_addr),
        .w_ena        (w_ena),
        .w_addr       (w_addr),
        .w_data       (w_data),
        .retire_valid (retire_valid),
        .retire_rd    (retire_rd),
        .retire_data  (retire_data),
        .illegal      (illegal)
    );

endmodule

// ==== test/tb_rv_exec.sv ====
`timescale 1ns/1ps

module tb_rv_exec;

    localparam int table_max = 64;
    localparam int group_count = 5;

    logic              clk;
    logic              rst;
    logic              instr_valid;
    rv_pkg::instr_t    instr;
    logic              retire_valid;
    rv_pkg::reg_addr_t retire_rd;
    rv_pkg::reg_t      retire_data;
    logic              illegal;

    // stimulus table
    int                tv_group   [0:table_max-1];
    rv_pkg::instr_t    tv_instr   [0:table_max-1];
    logic              tv_valid   [0:table_max-1];
    rv_pkg::reg_addr_t tv_rd      [0:table_max-1];
    rv_pkg::reg_t      tv_data    [0:table_max-1];
    logic              tv_illegal [0:table_max-1];
    string             group_name [0:group_count-1];
    int                n_entries;

    int   total_errors;
    int   group_errors;
    int   passed_tests;
    int   failed_tests;
    int   cycle_count;
    int   timeout_limit;
    logic table_ready;

    rv_exec_top DUT (
        .clk          (clk),
        .rst          (rst),
        .instr_valid  (instr_valid),
        .instr        (instr),
        .retire_valid (retire_valid),
        .retire_rd    (retire_rd),
        .retire_data  (retire_data),
        .illegal      (illegal)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #20 clk = ~clk;
        end
    end

    function automatic rv_pkg::instr_t r_type(
        input logic [6:0] funct7,
        input logic [4:0] rs2,
        input logic [4:0] rs1,
        input logic [2:0] funct3,
        input logic [4:0] rd,
        input logic [6:0] opcode
    );
        return {funct7, rs2, rs1, funct3, rd, opcode};
    endfunction

    function automatic rv_pkg::instr_t i_type(
        input logic [11:0] imm12,
        input logic [4:0]  rs1,
        input logic [2:0]  funct3,
        input logic [4:0]  rd
    );
        return {imm12, rs1, funct3, rd, rv_pkg::opc_op_imm};
    endfunction

    function automatic rv_pkg::instr_t u_type(
        input logic [19:0] imm20,
        input logic [4:0]  rd
    );
        return {imm20, rd, rv_pkg::opc_lui};
    endfunction

    task automatic add_entry(
        input int                group,
        input rv_pkg::instr_t    word,
        input logic              valid,
        input rv_pkg::reg_addr_t rd,
        input rv_pkg::reg_t      data,
        input logic              bad
    );
        tv_group[n_entries]   = group;
        tv_instr[n_entries]   = word;
        tv_valid[n_entries]   = valid;
        tv_rd[n_entries]      = rd;
        tv_data[n_entries]    = data;
        tv_illegal[n_entries] = bad;
        n_entries++;
    endtask

    task automatic add_legal(
        input int                group,
        input rv_pkg::instr_t    word,
        input rv_pkg::reg_addr_t rd,
        input rv_pkg::reg_t      data
    );
        add_entry(group, word, 1'b1, rd, data, 1'b0);
    endtask

    task automatic add_idle(input int group);
        add_entry(group, 32'h0, 1'b0, 5'd0, 64'h0, 1'b0);
    endtask

    task automatic add_illegal(input int group, input rv_pkg::instr_t word);
        add_entry(group, word, 1'b1, 5'd0, 64'h0, 1'b1);
    endtask

    task automatic build_table();
        n_entries = 0;
        group_name[0] = "reset state";
        group_name[1] = "immediates";
        group_name[2] = "register arithmetic";
        group_name[3] = "shifts and logic";
        group_name[4] = "r0 and illegal encodings";

        // nothing retires before the first instruction
        add_idle(0);
        add_idle(0);
        add_legal(0, r_type(7'h00, 5'd2, 5'd1, 3'b000, 5'd3, rv_pkg::opc_op), 5'd3, 64'h0);

        add_legal(1, i_type(12'hffb, 5'd0, 3'b000, 5'd1), 5'd1, 64'hffff_ffff_ffff_fffb);
        add_legal(1, u_type(20'h80000, 5'd2), 5'd2, 64'hffff_ffff_8000_0000);

        // add, sub use the result of the cycle before
        add_legal(2, r_type(7'h00, 5'd2, 5'd1, 3'b000, 5'd3, rv_pkg::opc_op),
                  5'd3, 64'hffff_ffff_7fff_fffb);
        add_legal(2, r_type(7'h20, 5'd1, 5'd3, 3'b000, 5'd4, rv_pkg::opc_op),
                  5'd4, 64'hffff_ffff_8000_0000);
        add_legal(2, i_type(12'h003, 5'd0, 3'b000, 5'd5), 5'd5, 64'h3);
        add_legal(2, r_type(7'h00, 5'd5, 5'd1, 3'b010, 5'd6, rv_pkg::opc_op), 5'd6, 64'h1);
        add_legal(2, r_type(7'h00, 5'd5, 5'd1, 3'b011, 5'd7, rv_pkg::opc_op), 5'd7, 64'h0);
        add_legal(2, i_type(12'h001, 5'd1, 3'b010, 5'd8), 5'd8, 64'h1);
        add_legal(2, i_type(12'h001, 5'd1, 3'b011, 5'd9), 5'd9, 64'h0);
        add_legal(2, r_type(7'h20, 5'd1, 5'd5, 3'b000, 5'd10, rv_pkg::opc_op), 5'd10, 64'h8);
        add_idle(2);

        // x1 holds -5
        add_legal(3, i_type(12'h03f, 5'd1, 3'b001, 5'd11), 5'd11, 64'h8000_0000_0000_0000);
        add_legal(3, i_type(12'h03f, 5'd1, 3'b101, 5'd12), 5'd12, 64'h1);
        add_legal(3, i_type(12'h43f, 5'd1, 3'b101, 5'd13), 5'd13, 64'hffff_ffff_ffff_ffff);
        add_legal(3, i_type(12'h020, 5'd1, 3'b001, 5'd14), 5'd14, 64'hffff_fffb_0000_0000);
        add_legal(3, i_type(12'h020, 5'd1, 3'b101, 5'd15), 5'd15, 64'h0000_0000_ffff_ffff);
        add_legal(3, i_type(12'h420, 5'd1, 3'b101, 5'd16), 5'd16, 64'hffff_ffff_ffff_ffff);
        // 0x44, only the low six bits (4) count
        add_legal(3, i_type(12'h044, 5'd0, 3'b000, 5'd17), 5'd17, 64'h44);
        add_legal(3, r_type(7'h00, 5'd17, 5'd1, 3'b001, 5'd18, rv_pkg::opc_op),
                  5'd18, 64'hffff_ffff_ffff_ffb0);
        add_legal(3, r_type(7'h00, 5'd17, 5'd1, 3'b101, 5'd19, rv_pkg::opc_op),
                  5'd19, 64'h0fff_ffff_ffff_ffff);
        add_legal(3, r_type(7'h20, 5'd17, 5'd1, 3'b101, 5'd20, rv_pkg::opc_op),
                  5'd20, 64'hffff_ffff_ffff_ffff);
        add_legal(3, r_type(7'h00, 5'd5, 5'd1, 3'b100, 5'd21, rv_pkg::opc_op),
                  5'd21, 64'hffff_ffff_ffff_fff8);
        add_legal(3, r_type(7'h00, 5'd5, 5'd1, 3'b110, 5'd22, rv_pkg::opc_op),
                  5'd22, 64'hffff_ffff_ffff_fffb);
        add_legal(3, r_type(7'h00, 5'd5, 5'd1, 3'b111, 5'd23, rv_pkg::opc_op), 5'd23, 64'h3);
        add_legal(3, i_type(12'h0f0, 5'd5, 3'b100, 5'd24), 5'd24, 64'hf3);
        add_legal(3, i_type(12'hff0, 5'd5, 3'b110, 5'd25), 5'd25, 64'hffff_ffff_ffff_fff3);
        add_legal(3, i_type(12'h7ff, 5'd1, 3'b111, 5'd26), 5'd26, 64'h7fb);
        add_idle(3);

        add_legal(4, i_type(12'h007, 5'd0, 3'b000, 5'd0), 5'd0, 64'h7);
        add_legal(4, r_type(7'h00, 5'd0, 5'd0, 3'b000, 5'd4, rv_pkg::opc_op), 5'd4, 64'h0);
        // sd x1, 5(x2) puts 5 in the rd field
        add_illegal(4, r_type(7'h00, 5'd1, 5'd2, 3'b011, 5'd5, 7'b0100011));
        add_legal(4, r_type(7'h00, 5'd0, 5'd5, 3'b000, 5'd27, rv_pkg::opc_op), 5'd27, 64'h3);
        // beq with 10 in the rd field
        add_illegal(4, r_type(7'h00, 5'd5, 5'd1, 3'b000, 5'd10, 7'b1100011));
        add_legal(4, i_type(12'h000, 5'd10, 3'b000, 5'd28), 5'd28, 64'h8);
        // funct7 0x01 is reserved here
        add_illegal(4, r_type(7'h01, 5'd5, 5'd1, 3'b000, 5'd23, rv_pkg::opc_op));
        add_legal(4, i_type(12'h000, 5'd23, 3'b000, 5'd29), 5'd29, 64'h3);
    endtask

    task automatic compare_value(
        input string       what,
        input logic [63:0] got,
        input logic [63:0] expected
    );
        if (got !== expected) begin
            $display("error at %0t ns: %s is %h, expected %h", $time, what, got, expected);
            total_errors++;
            group_errors++;
        end
    endtask

    task automatic check_entry(input int idx);
        logic exp_retire;
        logic exp_illegal;
        exp_retire  = tv_valid[idx] && !tv_illegal[idx];
        exp_illegal = tv_valid[idx] && tv_illegal[idx];
        compare_value($sformatf("entry %0d retire_valid", idx), 64'(retire_valid),
                      64'(exp_retire));
        compare_value($sformatf("entry %0d illegal", idx), 64'(illegal), 64'(exp_illegal));
        if (exp_retire) begin
            compare_value($sformatf("entry %0d retire_rd", idx), 64'(retire_rd),
                          64'(tv_rd[idx]));
            compare_value($sformatf("entry %0d retire_data", idx), retire_data, tv_data[idx]);
        end
    endtask

    task automatic report_group(input int group);
        if (group_errors == 0) begin
            $display("test %0d, %s: ok", group, group_name[group]);
            passed_tests++;
        end else begin
            $display("test %0d, %s: %0d mismatches", group, group_name[group], group_errors);
            failed_tests++;
        end
        group_errors = 0;
    endtask

    initial begin
        rst          = 1'b1;
        instr_valid  = 1'b0;
        instr        = 32'h0;
        total_errors = 0;
        group_errors = 0;
        passed_tests = 0;
        failed_tests = 0;
        table_ready  = 1'b0;
        build_table();
        timeout_limit = 8 + 2 * n_entries + 20;
        table_ready   = 1'b1;

        repeat (8) @(posedge clk);
        #5;
        rst = 1'b0;

        // one entry per cycle, checked after the next edge
        for (int i = 0; i < n_entries; i++) begin
            instr_valid = tv_valid[i];
            instr       = tv_instr[i];
            @(posedge clk);
            #5;
            instr_valid = 1'b0;
            check_entry(i);
            if ((i == n_entries - 1) || (tv_group[i + 1] != tv_group[i])) begin
                report_group(tv_group[i]);
            end
        end

        $display("summary: %0d tests passed, %0d tests failed, %0d mismatches",
                 passed_tests, failed_tests, total_errors);
        if ((failed_tests == 0) && (total_errors == 0)) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

    initial begin
        cycle_count = 0;
        wait (table_ready == 1'b1);
        while (cycle_count < timeout_limit) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout: the run did not finish within %0d clock cycles", timeout_limit);
        $display("Some tests failed");
        $finish;
    end

endmodule

// ==== list.f ====
design/rv_pkg.sv
design/regfile.sv
design/instr_decode.sv
design/alu.sv
design/rv_exec_top.sv
test/tb_rv_exec.sv

// ==== Bender.yml ====
package:
  name: rv_exec

sources:
  - design/rv_pkg.sv
  - design/regfile.sv
  - design/instr_decode.sv
  - design/alu.sv
  - design/rv_exec_top.sv
  - target: test
    files:
      - test/tb_rv_exec.sv
